/* Bender.yml */
package:
  name: peripheral_bus

sources:
  - design/pbus_pkg.sv
  - design/pbus_ctrl.sv
  - design/pbus_gpio.sv
  - design/pbus_timer.sv
  - design/peripheral_bus.sv
  - target: test
    files:
      - verif/pbus_checker.sv
      - verif/tb_peripheral_bus.sv

/* compile.f */
design/pbus_pkg.sv
design/pbus_ctrl.sv
design/pbus_gpio.sv
design/pbus_timer.sv
design/peripheral_bus.sv
verif/pbus_checker.sv
verif/tb_peripheral_bus.sv

/* design/pbus_ctrl.sv */
//////////////////////////////////////////////////
// axi4-lite slave for the peripheral bus
// one outstanding access, write wins over read
// region decode, request strobes, read-data select
//////////////////////////////////////////////////

module pbus_ctrl (
    input  logic                                    clock_i,
    input  logic                                    rst_n_i,
    // AW / W / B
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]    awaddr_i,
    input  logic                                    awvalid_i,
    output logic                                    awready_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    wdata_i,
    input  logic [pbus_pkg::PBUS_STRB_WIDTH-1:0]    wstrb_i,
    input  logic                                    wvalid_i,
    output logic                                    wready_o,
    output logic [1:0]                              bresp_o,
    output logic                                    bvalid_o,
    input  logic                                    bready_i,
    // AR / R
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]    araddr_i,
    input  logic                                    arvalid_i,
    output logic                                    arready_o,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    rdata_o,
    output logic [1:0]                              rresp_o,
    output logic                                    rvalid_o,
    input  logic                                    rready_i,
    // peripheral side
    output pbus_pkg::pbus_req_t                     gpio_req_o,
    output pbus_pkg::pbus_req_t                     tim0_req_o,
    output pbus_pkg::pbus_req_t                     tim1_req_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    gpio_rdata_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    tim0_rdata_i,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    tim1_rdata_i
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRESP,   // holding bvalid
        ST_RRESP    // holding rvalid
    } state_t;

    state_t state_q;
    logic   wr_acc, rd_acc;
    logic   mapped;
    logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]       acc_addr;
    logic [pbus_pkg::PBUS_REGION_WIDTH-1:0]     region;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]       sel_rdata;
    logic [1:0]                                 resp_q;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]       rdata_q;
    pbus_pkg::pbus_req_t                        base_req;

    // accept only from idle, write has priority
    assign wr_acc = (state_q == ST_IDLE) && awvalid_i && wvalid_i;
    assign rd_acc = (state_q == ST_IDLE) && arvalid_i && !(awvalid_i && wvalid_i);

    assign awready_o = wr_acc;  // aw and w taken together
    assign wready_o  = wr_acc;
    assign arready_o = rd_acc;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////
    assign acc_addr = wr_acc ? awaddr_i : araddr_i;
    assign region   = acc_addr[pbus_pkg::PBUS_REGION_LSB +: pbus_pkg::PBUS_REGION_WIDTH];
    assign mapped   = (region == pbus_pkg::PBUS_REGION_GPIO)
                   || (region == pbus_pkg::PBUS_REGION_TIM0)
                   || (region == pbus_pkg::PBUS_REGION_TIM1);

    always_comb begin
        base_req.wr     = 1'b0;
        base_req.rd     = 1'b0;
        base_req.offset = acc_addr[pbus_pkg::PBUS_REG_LSB +: pbus_pkg::PBUS_REG_OFFSET_WIDTH];
        base_req.wdata  = wdata_i;
        base_req.wstrb  = wstrb_i;

        gpio_req_o    = base_req;         // strobe only toward the addressed one
        gpio_req_o.wr = wr_acc && (region == pbus_pkg::PBUS_REGION_GPIO);
        gpio_req_o.rd = rd_acc && (region == pbus_pkg::PBUS_REGION_GPIO);
        tim0_req_o    = base_req;
        tim0_req_o.wr = wr_acc && (region == pbus_pkg::PBUS_REGION_TIM0);
        tim0_req_o.rd = rd_acc && (region == pbus_pkg::PBUS_REGION_TIM0);
        tim1_req_o    = base_req;
        tim1_req_o.wr = wr_acc && (region == pbus_pkg::PBUS_REGION_TIM1);
        tim1_req_o.rd = rd_acc && (region == pbus_pkg::PBUS_REGION_TIM1);
    end

    always_comb begin
        case (region)
            pbus_pkg::PBUS_REGION_GPIO: sel_rdata = gpio_rdata_i;
            pbus_pkg::PBUS_REGION_TIM0: sel_rdata = tim0_rdata_i;
            pbus_pkg::PBUS_REGION_TIM1: sel_rdata = tim1_rdata_i;
            default:                    sel_rdata = '0;  // unmapped reads zero
        endcase
    end

    //////////////////////////////////////////////////
    // fsm and response registers
    //////////////////////////////////////////////////
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            resp_q  <= pbus_pkg::RESP_OKAY;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (wr_acc || rd_acc) begin
                        resp_q <= mapped ? pbus_pkg::RESP_OKAY : pbus_pkg::RESP_DECERR;
                    end
                    if (wr_acc)      state_q <= ST_WRESP;
                    else if (rd_acc) state_q <= ST_RRESP;
                end
                ST_WRESP: if (bready_i) state_q <= ST_IDLE;
                ST_RRESP: if (rready_i) state_q <= ST_IDLE;
                default:  state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdata_q <= '0;
        end else if (rd_acc) begin
            rdata_q <= sel_rdata;  // captured on the ar handshake
        end
    end

    assign bvalid_o = (state_q == ST_WRESP);
    assign rvalid_o = (state_q == ST_RRESP);
    assign bresp_o  = resp_q;
    assign rresp_o  = resp_q;
    assign rdata_o  = rdata_q;

    // one response channel at a time
    a_one_resp: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        !(bvalid_o && rvalid_o));

    // pending response blocks any new address
    a_no_ready_busy: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        (bvalid_o || rvalid_o) |-> !(awready_o || wready_o || arready_o));

endmodule : pbus_ctrl

/* design/pbus_gpio.sv */
//////////////////////////////////////////////////
// gpio peripheral
// output register, 2-flop input sync
// rising-edge status with w1c and interrupt
//////////////////////////////////////////////////

module pbus_gpio (
    input  logic                                    clock_i,
    input  logic                                    rst_n_i,
    input  pbus_pkg::pbus_req_t                     req_i,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    rdata_o,
    input  logic [pbus_pkg::NUM_GPIO_IN-1:0]        gpio_in_i,
    output logic [pbus_pkg::NUM_GPIO_OUT-1:0]       gpio_out_o,
    output logic                                    irq_o
);

    logic [pbus_pkg::NUM_GPIO_OUT-1:0]  out_q;
    logic [pbus_pkg::NUM_GPIO_IN-1:0]   en_q, status_q;
    logic [pbus_pkg::NUM_GPIO_IN-1:0]   sync1_q, sync2_q, prev_q;
    logic [pbus_pkg::NUM_GPIO_IN-1:0]   rise, clr;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] out_word, in_word, en_word, stat_word;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] out_merge, en_merge;

    // zero-extended register views
    assign out_word  = {{(pbus_pkg::PBUS_DATA_WIDTH-pbus_pkg::NUM_GPIO_OUT){1'b0}}, out_q};
    assign in_word   = {{(pbus_pkg::PBUS_DATA_WIDTH-pbus_pkg::NUM_GPIO_IN){1'b0}}, sync2_q};
    assign en_word   = {{(pbus_pkg::PBUS_DATA_WIDTH-pbus_pkg::NUM_GPIO_IN){1'b0}}, en_q};
    assign stat_word = {{(pbus_pkg::PBUS_DATA_WIDTH-pbus_pkg::NUM_GPIO_IN){1'b0}}, status_q};

    assign out_merge = pbus_pkg::strb_merge(out_word, req_i.wdata, req_i.wstrb);
    assign en_merge  = pbus_pkg::strb_merge(en_word, req_i.wdata, req_i.wstrb);

    assign rise = sync2_q & ~prev_q;  // low to high on synced input
    assign clr  = (req_i.wr && req_i.offset == pbus_pkg::GPIO_IRQ_STATUS)
                ? req_i.wdata[pbus_pkg::NUM_GPIO_IN-1:0] : '0;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q    <= '0;
            en_q     <= '0;
            status_q <= '0;
            sync1_q  <= '0;
            sync2_q  <= '0;
            prev_q   <= '0;
        end else begin
            sync1_q  <= gpio_in_i;
            sync2_q  <= sync1_q;
            prev_q   <= sync2_q;
            status_q <= (status_q & ~clr) | rise;  // new edge beats the clear
            if (req_i.wr && req_i.offset == pbus_pkg::GPIO_DATA_OUT) begin
                out_q <= out_merge[pbus_pkg::NUM_GPIO_OUT-1:0];
            end
            if (req_i.wr && req_i.offset == pbus_pkg::GPIO_IRQ_EN) begin
                en_q <= en_merge[pbus_pkg::NUM_GPIO_IN-1:0];
            end
        end
    end

    always_comb begin
        case (req_i.offset)
            pbus_pkg::GPIO_DATA_OUT: rdata_o = out_word;
            pbus_pkg::GPIO_DATA_IN:  rdata_o = in_word;
            pbus_pkg::GPIO_IRQ_EN:   rdata_o = en_word;
            default:                 rdata_o = stat_word;
        endcase
    end

    assign gpio_out_o = out_q;
    assign irq_o      = |(status_q & en_q);

    a_irq_needs_en: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        (en_q == '0) |-> !irq_o);

endmodule : pbus_gpio

/* design/pbus_pkg.sv */
//////////////////////////////////////////////////
// peripheral bus package
// bus widths, address map and register offsets
// response codes and interrupt indices
// request struct and byte-strobe merge function
//////////////////////////////////////////////////

package pbus_pkg;

    // bus geometry
    localparam int unsigned PBUS_DATA_WIDTH = 32;
    localparam int unsigned PBUS_ADDR_WIDTH = 32;
    localparam int unsigned PBUS_STRB_WIDTH = PBUS_DATA_WIDTH / 8;

    // address map, addr[9:8] picks the peripheral
    localparam int unsigned PBUS_REGION_LSB   = 8;
    localparam int unsigned PBUS_REGION_WIDTH = 2;
    localparam logic [PBUS_REGION_WIDTH-1:0] PBUS_REGION_GPIO = 2'd0;
    localparam logic [PBUS_REGION_WIDTH-1:0] PBUS_REGION_TIM0 = 2'd1;
    localparam logic [PBUS_REGION_WIDTH-1:0] PBUS_REGION_TIM1 = 2'd2;  // region 3 unmapped

    // four word registers per peripheral, addr[3:2]
    localparam int unsigned PBUS_REG_LSB          = 2;
    localparam int unsigned PBUS_REG_OFFSET_WIDTH = 2;

    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] GPIO_DATA_OUT   = 2'd0;
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] GPIO_DATA_IN    = 2'd1;  // read only
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] GPIO_IRQ_EN     = 2'd2;
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] GPIO_IRQ_STATUS = 2'd3;  // w1c

    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] TIM_CTRL   = 2'd0;
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] TIM_LOAD   = 2'd1;
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] TIM_COUNT  = 2'd2;  // read only
    localparam logic [PBUS_REG_OFFSET_WIDTH-1:0] TIM_STATUS = 2'd3;  // w1c expired

    // timer control word bits
    localparam int unsigned TIM_CTRL_EN     = 0;
    localparam int unsigned TIM_CTRL_RELOAD = 1;
    localparam int unsigned TIM_CTRL_IRQ_EN = 2;

    localparam int unsigned NUM_GPIO_IN  = 8;
    localparam int unsigned NUM_GPIO_OUT = 8;

    // interrupt vector layout
    localparam int unsigned NUM_IRQ               = 3;
    localparam int unsigned PBUS_GPIOIN_INTERRUPT = 0;
    localparam int unsigned PBUS_TIM0_INTERRUPT   = 1;
    localparam int unsigned PBUS_TIM1_INTERRUPT   = 2;

    // axi responses
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_DECERR = 2'b11;

    //////////////////////////////////////////////////
    // request from the bus controller to a peripheral
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                             wr;      // one-cycle write strobe
        logic                             rd;      // one-cycle read strobe
        logic [PBUS_REG_OFFSET_WIDTH-1:0] offset;  // register select
        logic [PBUS_DATA_WIDTH-1:0]       wdata;
        logic [PBUS_STRB_WIDTH-1:0]       wstrb;
    } pbus_req_t;

    // byte-wise merge of write data into an old register value
    function automatic logic [PBUS_DATA_WIDTH-1:0] strb_merge(
        input logic [PBUS_DATA_WIDTH-1:0] old_val,
        input logic [PBUS_DATA_WIDTH-1:0] wdata,
        input logic [PBUS_STRB_WIDTH-1:0] wstrb
    );
        logic [PBUS_DATA_WIDTH-1:0] res;
        res = old_val;
        for (int b = 0; b < PBUS_STRB_WIDTH; b++) begin
            if (wstrb[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
        end
        return res;
    endfunction

endpackage : pbus_pkg

/* design/pbus_timer.sv */
//////////////////////////////////////////////////
// down-counting timer
// load, auto-reload, sticky expiry, interrupt
//////////////////////////////////////////////////

module pbus_timer (
    input  logic                                    clock_i,
    input  logic                                    rst_n_i,
    input  pbus_pkg::pbus_req_t                     req_i,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    rdata_o,
    output logic                                    irq_o
);

    logic [pbus_pkg::TIM_CTRL_IRQ_EN:0]     ctrl_q;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]   load_q, count_q;
    logic                                   expired_q;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]   ctrl_word, ctrl_merge, load_merge;
    logic                                   wr_ctrl, wr_load, wr_stat;
    logic                                   en, at_zero;

    assign ctrl_word  = {{(pbus_pkg::PBUS_DATA_WIDTH-pbus_pkg::TIM_CTRL_IRQ_EN-1){1'b0}},
                         ctrl_q};
    assign ctrl_merge = pbus_pkg::strb_merge(ctrl_word, req_i.wdata, req_i.wstrb);
    assign load_merge = pbus_pkg::strb_merge(load_q, req_i.wdata, req_i.wstrb);

    assign wr_ctrl = req_i.wr && (req_i.offset == pbus_pkg::TIM_CTRL);
    assign wr_load = req_i.wr && (req_i.offset == pbus_pkg::TIM_LOAD);
    assign wr_stat = req_i.wr && (req_i.offset == pbus_pkg::TIM_STATUS);

    assign en      = ctrl_q[pbus_pkg::TIM_CTRL_EN];
    assign at_zero = (count_q == '0);

    //////////////////////////////////////////////////
    // counter
    //////////////////////////////////////////////////
    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ctrl_q    <= '0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
        end else begin
            if (wr_stat && req_i.wdata[0]) expired_q <= 1'b0;  // w1c

            if (en) begin
                if (at_zero) begin
                    expired_q <= 1'b1;  // set wins over clear
                    if (ctrl_q[pbus_pkg::TIM_CTRL_RELOAD]) count_q <= load_q;
                    else ctrl_q[pbus_pkg::TIM_CTRL_EN] <= 1'b0;  // one-shot stops
                end else begin
                    count_q <= count_q - 1'b1;
                end
            end

            // bus writes override the counter update
            if (wr_ctrl) ctrl_q <= ctrl_merge[pbus_pkg::TIM_CTRL_IRQ_EN:0];
            if (wr_load) begin
                load_q  <= load_merge;
                count_q <= load_merge;  // load also restarts the count
            end
        end
    end

    always_comb begin
        case (req_i.offset)
            pbus_pkg::TIM_CTRL:  rdata_o = ctrl_word;
            pbus_pkg::TIM_LOAD:  rdata_o = load_q;
            pbus_pkg::TIM_COUNT: rdata_o = count_q;
            default:             rdata_o = {{(pbus_pkg::PBUS_DATA_WIDTH-1){1'b0}}, expired_q};
        endcase
    end

    assign irq_o = expired_q && ctrl_q[pbus_pkg::TIM_CTRL_IRQ_EN];

    // count only ever moves down from load
    a_count_le_load: assert property (@(posedge clock_i) disable iff (!rst_n_i)
        en |-> (count_q <= load_q));

endmodule : pbus_timer

/* design/peripheral_bus.sv */
//////////////////////////////////////////////////
// peripheral bus top level
// axi4-lite controller, gpio, two timers
// interrupt vector assembly
//////////////////////////////////////////////////

module peripheral_bus (
    input  logic                                    clock_i,
    input  logic                                    rst_n_i,
    // axi4-lite slave
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]    awaddr_i,
    input  logic                                    awvalid_i,
    output logic                                    awready_o,
    input  logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    wdata_i,
    input  logic [pbus_pkg::PBUS_STRB_WIDTH-1:0]    wstrb_i,
    input  logic                                    wvalid_i,
    output logic                                    wready_o,
    output logic [1:0]                              bresp_o,
    output logic                                    bvalid_o,
    input  logic                                    bready_i,
    input  logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0]    araddr_i,
    input  logic                                    arvalid_i,
    output logic                                    arready_o,
    output logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]    rdata_o,
    output logic [1:0]                              rresp_o,
    output logic                                    rvalid_o,
    input  logic                                    rready_i,
    // pins
    input  logic [pbus_pkg::NUM_GPIO_IN-1:0]        gpio_in_i,
    output logic [pbus_pkg::NUM_GPIO_OUT-1:0]       gpio_out_o,
    output logic [pbus_pkg::NUM_IRQ-1:0]            int_o
);

    pbus_pkg::pbus_req_t                    gpio_req, tim0_req, tim1_req;
    logic [pbus_pkg::PBUS_DATA_WIDTH-1:0]   gpio_rdata, tim0_rdata, tim1_rdata;
    logic                                   gpio_int, tim0_int, tim1_int;

    assign int_o[pbus_pkg::PBUS_GPIOIN_INTERRUPT] = gpio_int;
    assign int_o[pbus_pkg::PBUS_TIM0_INTERRUPT]   = tim0_int;
    assign int_o[pbus_pkg::PBUS_TIM1_INTERRUPT]   = tim1_int;

    pbus_ctrl ctrl_u (
        .clock_i      ( clock_i    ),
        .rst_n_i      ( rst_n_i    ),
        .awaddr_i     ( awaddr_i   ),
        .awvalid_i    ( awvalid_i  ),
        .awready_o    ( awready_o  ),
        .wdata_i      ( wdata_i    ),
        .wstrb_i      ( wstrb_i    ),
        .wvalid_i     ( wvalid_i   ),
        .wready_o     ( wready_o   ),
        .bresp_o      ( bresp_o    ),
        .bvalid_o     ( bvalid_o   ),
        .bready_i     ( bready_i   ),
        .araddr_i     ( araddr_i   ),
        .arvalid_i    ( arvalid_i  ),
        .arready_o    ( arready_o  ),
        .rdata_o      ( rdata_o    ),
        .rresp_o      ( rresp_o    ),
        .rvalid_o     ( rvalid_o   ),
        .rready_i     ( rready_i   ),
        .gpio_req_o   ( gpio_req   ),
        .tim0_req_o   ( tim0_req   ),
        .tim1_req_o   ( tim1_req   ),
        .gpio_rdata_i ( gpio_rdata ),
        .tim0_rdata_i ( tim0_rdata ),
        .tim1_rdata_i ( tim1_rdata )
    );

    pbus_gpio gpio_u (
        .clock_i    ( clock_i    ),
        .rst_n_i    ( rst_n_i    ),
        .req_i      ( gpio_req   ),
        .rdata_o    ( gpio_rdata ),
        .gpio_in_i  ( gpio_in_i  ),
        .gpio_out_o ( gpio_out_o ),
        .irq_o      ( gpio_int   )
    );

    pbus_timer tim0_u (
        .clock_i ( clock_i    ),
        .rst_n_i ( rst_n_i    ),
        .req_i   ( tim0_req   ),
        .rdata_o ( tim0_rdata ),
        .irq_o   ( tim0_int   )
    );

    pbus_timer tim1_u (
        .clock_i ( clock_i    ),
        .rst_n_i ( rst_n_i    ),
        .req_i   ( tim1_req   ),
        .rdata_o ( tim1_rdata ),
        .irq_o   ( tim1_int   )
    );

endmodule : peripheral_bus

/* verif/pbus_checker.sv */
//////////////////////////////////////////////////
// response and pin checker for the peripheral bus
// compares at each B and R handshake
// per-test result lines and closing counts
//////////////////////////////////////////////////

module pbus_checker (
    input logic        clock_i,
    input logic        rst_n_i,
    input logic        bvalid_i,
    input logic        bready_i,
    input logic [1:0]  bresp_i,
    input logic        rvalid_i,
    input logic        rready_i,
    input logic [31:0] rdata_i,
    input logic [1:0]  rresp_i,
    input logic [7:0]  gpio_out_i,
    input logic [2:0]  int_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int          pass_count = 0;
    int          fail_count = 0;
    string       exp_name;
    logic        exp_pending = 1'b0;  // one access outstanding
    logic        exp_read;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;

    task automatic expect_resp(input string name, input logic is_read,
                               input logic [31:0] data, input logic [1:0] resp);
        exp_name    = name;
        exp_read    = is_read;
        exp_data    = data;
        exp_resp    = resp;
        exp_pending = 1'b1;
    endtask

    task automatic score(input string name, input logic [31:0] e_data, input logic [31:0] a_data,
                         input logic [1:0] e_resp, input logic [1:0] a_resp);
        if (a_resp !== e_resp) begin
            $display("Mismatch in %s: expected resp %0d, actual %0d", name, e_resp, a_resp);
            fail_count++;
        end else if (a_data !== e_data) begin
            $display("Mismatch in %s: expected %h, actual %h", name, e_data, a_data);
            fail_count++;
        end else begin
            $display("ok    %s", name);
            pass_count++;
        end
    endtask

    task automatic check_pins(input string name, input logic [31:0] exp);
        score(name, exp, {21'h0, int_i, gpio_out_i}, 2'd0, 2'd0);  // {int_o, gpio_out_o}
    endtask

    task automatic report_timeout(input string name, input string what);
        $display("Timeout in %s: %s never came up", name, what);
        fail_count++;
        exp_pending = 1'b0;
    endtask

    task automatic print_counts();
        $display("%0d tests passed, %0d failed", pass_count, fail_count);
    endtask

    //////////////////////////////////////////////////
    // handshake monitor
    //////////////////////////////////////////////////
    always @(posedge clock_i) begin
        if (rst_n_i && bvalid_i && bready_i) begin
            if (!exp_pending || exp_read) begin
                $display("Error: write response arrived with no write outstanding");
                fail_count++;
            end else begin
                score(exp_name, 32'h0, 32'h0, exp_resp, bresp_i);
            end
            exp_pending = 1'b0;
        end
        if (rst_n_i && rvalid_i && rready_i) begin
            if (!exp_pending || !exp_read) begin
                $display("Error: read response arrived with no read outstanding");
                fail_count++;
            end else begin
                score(exp_name, exp_data, rdata_i, exp_resp, rresp_i);
            end
            exp_pending = 1'b0;
        end
    end

endmodule : pbus_checker

/* verif/tb_peripheral_bus.sv */
//////////////////////////////////////////////////
// testbench for the peripheral bus
// clock, reset, stimulus table and row loop
// axi4-lite master driving with per-wait timeouts
//////////////////////////////////////////////////

module tb_peripheral_bus;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_ROWS = 48;
    localparam int TIMEOUT  = 100;  // cycles per wait
    localparam logic [1:0] OP_WR  = 2'd0;
    localparam logic [1:0] OP_RD  = 2'd1;
    localparam logic [1:0] OP_IRQ = 2'd2;  // wait for int_o bits in data
    localparam logic [1:0] OP_PIN = 2'd3;  // check pins right away
    localparam int W_AW = 0;
    localparam int W_B  = 1;
    localparam int W_AR = 2;
    localparam int W_R  = 3;
    localparam int W_IRQ = 4;

    typedef struct packed {
        logic [1:0]                           op;
        logic [pbus_pkg::PBUS_ADDR_WIDTH-1:0] addr;
        logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] data;
        logic [pbus_pkg::PBUS_STRB_WIDTH-1:0] strb;
        logic [pbus_pkg::NUM_GPIO_IN-1:0]     gpio_in;   // pin level for the row
        logic [pbus_pkg::PBUS_DATA_WIDTH-1:0] exp_data;  // pin rows: {int_o, gpio_out_o}
        logic [1:0]                           exp_resp;
    } row_t;

    logic        clock, rst_n;
    logic [31:0] awaddr, wdata, araddr, rdata;
    logic [3:0]  wstrb;
    logic        awvalid, awready, wvalid, wready, bvalid, bready;
    logic        arvalid, arready, rvalid, rready;
    logic [1:0]  bresp, rresp;
    logic [7:0]  gpio_in, gpio_out;
    logic [2:0]  int_o;
    row_t        rows [0:MAX_ROWS-1];
    string       names [0:MAX_ROWS-1];
    int          n_rows = 0;
    logic        timed_out = 1'b0;
    integer      seed;

    always #2 clock = ~clock;  // 4 ns period

    peripheral_bus UUT (
        .clock_i (clock), .rst_n_i (rst_n),
        .awaddr_i (awaddr), .awvalid_i (awvalid), .awready_o (awready),
        .wdata_i (wdata), .wstrb_i (wstrb), .wvalid_i (wvalid), .wready_o (wready),
        .bresp_o (bresp), .bvalid_o (bvalid), .bready_i (bready),
        .araddr_i (araddr), .arvalid_i (arvalid), .arready_o (arready),
        .rdata_o (rdata), .rresp_o (rresp), .rvalid_o (rvalid), .rready_i (rready),
        .gpio_in_i (gpio_in), .gpio_out_o (gpio_out), .int_o (int_o)
    );

    pbus_checker chk_u (
        .clock_i (clock), .rst_n_i (rst_n),
        .bvalid_i (bvalid), .bready_i (bready), .bresp_i (bresp),
        .rvalid_i (rvalid), .rready_i (rready), .rdata_i (rdata), .rresp_i (rresp),
        .gpio_out_i (gpio_out), .int_i (int_o)
    );

    task automatic add_row(input string name, input logic [1:0] op, input logic [31:0] addr,
                           input logic [31:0] data, input logic [3:0] strb,
                           input logic [7:0] gin, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp);
        names[n_rows] = name;
        rows[n_rows]  = {op, addr, data, strb, gin, exp_data, exp_resp};
        n_rows++;
    endtask

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////
    task automatic build_table();
        logic [31:0] rnd;
        add_row("reset_pins",          OP_PIN, 32'h000, 0,     4'h0, 8'h00, 32'h000, 2'd0);
        add_row("reset_gpio_out",      OP_RD,  32'h000, 0,     4'h0, 8'h00, 32'h000, 2'd0);
        add_row("reset_tim0_load",     OP_RD,  32'h104, 0,     4'h0, 8'h00, 32'h000, 2'd0);
        add_row("gpio_out_full",       OP_WR,  32'h000, 'hA5,  4'hF, 8'h00, 32'h000, 2'd0);
        add_row("gpio_out_strb_skip",  OP_WR,  32'h000, 'h5A,  4'h2, 8'h00, 32'h000, 2'd0);
        add_row("gpio_out_merged_rd",  OP_RD,  32'h000, 0,     4'h0, 8'h00, 32'h0A5, 2'd0);
        add_row("gpio_out_merged_pin", OP_PIN, 32'h000, 0,     4'h0, 8'h00, 32'h0A5, 2'd0);
        add_row("gpio_out_byte0",      OP_WR,  32'h000, 'h3C,  4'h1, 8'h00, 32'h000, 2'd0);
        add_row("gpio_out_byte0_rd",   OP_RD,  32'h000, 0,     4'h0, 8'h00, 32'h03C, 2'd0);
        add_row("gpio_irq_en",         OP_WR,  32'h008, 'h04,  4'hF, 8'h00, 32'h000, 2'd0);
        add_row("gpio_edge_irq",       OP_IRQ, 32'h000, 'h1,   4'h0, 8'h04, 32'h13C, 2'd0);
        add_row("gpio_data_in",        OP_RD,  32'h004, 0,     4'h0, 8'h04, 32'h004, 2'd0);
        add_row("gpio_status",         OP_RD,  32'h00C, 0,     4'h0, 8'h04, 32'h004, 2'd0);
        add_row("gpio_status_clr",     OP_WR,  32'h00C, 'h04,  4'hF, 8'h04, 32'h000, 2'd0);
        add_row("gpio_status_clr_rd",  OP_RD,  32'h00C, 0,     4'h0, 8'h04, 32'h000, 2'd0);
        add_row("gpio_irq_cleared",    OP_PIN, 32'h000, 0,     4'h0, 8'h04, 32'h03C, 2'd0);
        add_row("tim0_load",           OP_WR,  32'h104, 'h5,   4'hF, 8'h04, 32'h000, 2'd0);
        add_row("tim0_ctrl",           OP_WR,  32'h100, 'h5,   4'hF, 8'h04, 32'h000, 2'd0);
        add_row("tim0_expire_irq",     OP_IRQ, 32'h000, 'h2,   4'h0, 8'h04, 32'h23C, 2'd0);
        add_row("tim0_status",         OP_RD,  32'h10C, 0,     4'h0, 8'h04, 32'h001, 2'd0);
        add_row("tim0_ctrl_en_off",    OP_RD,  32'h100, 0,     4'h0, 8'h04, 32'h004, 2'd0);
        add_row("tim0_status_clr",     OP_WR,  32'h10C, 'h1,   4'hF, 8'h04, 32'h000, 2'd0);
        add_row("tim0_irq_cleared",    OP_PIN, 32'h000, 0,     4'h0, 8'h04, 32'h03C, 2'd0);
        add_row("unmapped_wr",         OP_WR,  32'h300, 'h1,   4'hF, 8'h04, 32'h000, 2'd3);
        add_row("unmapped_rd",         OP_RD,  32'h30C, 0,     4'h0, 8'h04, 32'h000, 2'd3);
        add_row("gpio_in_ro_wr",       OP_WR,  32'h004, 'hFF,  4'hF, 8'h04, 32'h000, 2'd0);
        add_row("gpio_in_ro_rd",       OP_RD,  32'h004, 0,     4'h0, 8'h04, 32'h004, 2'd0);
        add_row("tim0_count_ro_wr",    OP_WR,  32'h108, 'h55,  4'hF, 8'h04, 32'h000, 2'd0);
        add_row("tim0_count_ro_rd",    OP_RD,  32'h108, 0,     4'h0, 8'h04, 32'h000, 2'd0);
        for (int i = 0; i < 2; i++) begin
            rnd = $random(seed);  // gpio keeps only the low byte
            add_row($sformatf("rnd%0d_gpio_wr", i), OP_WR, 32'h000, rnd, 4'hF, 8'h04, 0, 2'd0);
            add_row($sformatf("rnd%0d_gpio_rd", i), OP_RD, 32'h000, 0, 4'h0, 8'h04,
                    {24'h0, rnd[7:0]}, 2'd0);
            rnd = $random(seed);
            add_row($sformatf("rnd%0d_tim1_wr", i), OP_WR, 32'h204, rnd, 4'hF, 8'h04, 0, 2'd0);
            add_row($sformatf("rnd%0d_tim1_rd", i), OP_RD, 32'h204, 0, 4'h0, 8'h04, rnd, 2'd0);
        end
    endtask

    function automatic logic is_up(input int which, input logic [2:0] mask);
        case (which)
            W_AW:    return awready && wready;  // aw and w must pulse together
            W_B:     return bvalid;
            W_AR:    return arready;
            W_R:     return rvalid;
            default: return |(int_o & mask);
        endcase
    endfunction

    task automatic wait_up(input int which, input logic [2:0] mask, input string name,
                           input string what, output logic ok);
        int cnt;
        cnt = 0;
        ok  = 1'b0;
        while (!ok && cnt < TIMEOUT) begin
            @(posedge clock);
            cnt++;
            ok = is_up(which, mask);  // pre-edge value, the one the edge used
        end
        if (!ok) begin
            chk_u.report_timeout(name, what);
            timed_out = 1'b1;
        end
    endtask

    //////////////////////////////////////////////////
    // bus driver for one row
    //////////////////////////////////////////////////
    task automatic run_row(input int idx);
        row_t r;
        logic ok;
        r = rows[idx];
        @(posedge clock);
        gpio_in <= r.gpio_in;
        case (r.op)
            OP_WR: begin
                chk_u.expect_resp(names[idx], 1'b0, '0, r.exp_resp);
                awaddr  <= r.addr;
                wdata   <= r.data;
                wstrb   <= r.strb;
                awvalid <= 1'b1;
                wvalid  <= 1'b1;
                bready  <= 1'b1;
                wait_up(W_AW, 3'b0, names[idx], "awready and wready", ok);
                awvalid <= 1'b0;
                wvalid  <= 1'b0;
                if (ok) wait_up(W_B, 3'b0, names[idx], "bvalid", ok);
                bready  <= 1'b0;
            end
            OP_RD: begin
                chk_u.expect_resp(names[idx], 1'b1, r.exp_data, r.exp_resp);
                araddr  <= r.addr;
                arvalid <= 1'b1;
                rready  <= 1'b1;
                wait_up(W_AR, 3'b0, names[idx], "arready", ok);
                arvalid <= 1'b0;
                if (ok) wait_up(W_R, 3'b0, names[idx], "rvalid", ok);
                rready  <= 1'b0;
            end
            OP_IRQ: begin
                wait_up(W_IRQ, r.data[2:0], names[idx], "interrupt", ok);
                if (ok) chk_u.check_pins(names[idx], r.exp_data);
            end
            default: chk_u.check_pins(names[idx], r.exp_data);
        endcase
    endtask

    initial begin
        clock   = 1'b0;
        seed    = 79;
        rst_n   <= 1'b0;
        awaddr  <= '0;
        wdata   <= '0;
        wstrb   <= '0;
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        bready  <= 1'b0;
        araddr  <= '0;
        arvalid <= 1'b0;
        rready  <= 1'b0;
        gpio_in <= '0;
        build_table();
        repeat (4) @(posedge clock);
        rst_n <= 1'b1;
        for (int i = 0; i < n_rows && !timed_out; i++) begin
            run_row(i);
        end
        repeat (4) @(posedge clock);
        chk_u.print_counts();
        if (!timed_out && chk_u.fail_count == 0 && chk_u.pass_count == n_rows) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : tb_peripheral_bus
